//--- bench/tb_lc4_pipeline.sv
// **************************************************************************
// LC4 pipeline testbench
// runs a program table through the DUT and checks the retirement trace
// **************************************************************************
`timescale 1ns/10ps
`include "lc4_config.svh"

module tb_lc4_pipeline;
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    localparam int MAX_ENTRIES = 32;

    logic gwe, i_rst;
    word_t o_cur_pc, o_dmem_addr, o_dmem_towrite, i_cur_dmem_data;
    insn_t i_cur_insn, o_test_cur_insn;
    logic o_dmem_we, o_test_regfile_we, o_test_nzp_we, o_test_dmem_we;
    stall_t o_test_stall;
    word_t o_test_cur_pc, o_test_regfile_data, o_test_dmem_addr, o_test_dmem_data;
    reg_sel_t o_test_regfile_wsel;
    nzp_t o_test_nzp_new_bits;

    word_t imem [0:65535];
    word_t dmem [0:65535];
    logic [31:0] lfsr_state;
    int err_count;
    int check_count;
    int n_entries;

    // program and expected retirement with one row per retired instruction
    word_t    e_pc [MAX_ENTRIES];
    insn_t    e_insn [MAX_ENTRIES];
    int       e_bubbles [MAX_ENTRIES];
    stall_t   e_bcode [MAX_ENTRIES];
    logic     e_rf_we [MAX_ENTRIES];
    reg_sel_t e_wsel [MAX_ENTRIES];
    word_t    e_data [MAX_ENTRIES];
    nzp_t     e_nzp [MAX_ENTRIES];
    logic     e_dm_we [MAX_ENTRIES];
    word_t    e_dm_addr [MAX_ENTRIES];
    word_t    e_dm_data [MAX_ENTRIES];

    lc4_pipeline u_lc4_pipeline (.*);

    initial gwe = 1'b0;
    always #50 gwe = ~gwe;

    // memories answer the current fetch and M-stage addresses
    always @(negedge gwe) begin
        i_cur_insn      <= imem[o_cur_pc];
        i_cur_dmem_data <= dmem[o_dmem_addr];
    end

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr] <= o_dmem_towrite;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic lfsr_word(output word_t w);
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    // condition bits from the sign of a result
    function automatic nzp_t sign_bits(input word_t v);
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return v[15] ? 3'b100 : 3'b001;
    endfunction

    task automatic add_entry(input word_t pc, input insn_t insn, input int bubbles,
                             input stall_t bcode);
        imem[pc]             = insn;
        e_pc[n_entries]      = pc;
        e_insn[n_entries]    = insn;
        e_bubbles[n_entries] = bubbles;
        e_bcode[n_entries]   = bcode;
        e_rf_we[n_entries]   = 1'b0;
        e_wsel[n_entries]    = '0;
        e_data[n_entries]    = '0;
        e_nzp[n_entries]     = '0;
        e_dm_we[n_entries]   = 1'b0;
        e_dm_addr[n_entries] = '0;
        e_dm_data[n_entries] = '0;
        n_entries++;
    endtask

    task automatic set_rf(input reg_sel_t wsel, input word_t data, input nzp_t nzp);
        e_rf_we[n_entries-1] = 1'b1;
        e_wsel[n_entries-1]  = wsel;
        e_data[n_entries-1]  = data;
        e_nzp[n_entries-1]   = nzp;
    endtask

    task automatic set_mem(input logic we, input word_t addr, input word_t data);
        e_dm_we[n_entries-1]   = we;
        e_dm_addr[n_entries-1] = addr;
        e_dm_data[n_entries-1] = data;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_insn(input string what, input insn_t got, input insn_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(input string what, input reg_sel_t got, input reg_sel_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_nzp(input string what, input nzp_t got, input nzp_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_stall(input string what, input stall_t got, input stall_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic build_program();
        word_t ld_val;
        word_t sum;
        ld_val = dmem[16'h0042];
        sum    = ld_val + 16'h0040;
        // the first fetch reaches W four cycles after reset drops
        add_entry(16'h8200, 16'h9240, 3, `LC4_STALL_BRANCH);
        set_rf(3'd1, 16'h0040, 3'b001);
        add_entry(16'h8201, 16'h95FD, 0, `LC4_STALL_NONE);
        set_rf(3'd2, 16'hFFFD, 3'b100);
        // back-to-back and one-apart dependencies
        add_entry(16'h8202, 16'h1642, 0, `LC4_STALL_NONE);
        set_rf(3'd3, 16'h003D, 3'b001);
        add_entry(16'h8203, 16'h1893, 0, `LC4_STALL_NONE);
        set_rf(3'd4, 16'hFFC0, 3'b100);
        add_entry(16'h8204, 16'h5B1C, 0, `LC4_STALL_NONE);
        set_rf(3'd5, 16'h0000, 3'b010);
        add_entry(16'h8205, 16'h5CC8, 0, `LC4_STALL_NONE);
        set_rf(3'd6, 16'hFFC2, 3'b100);
        add_entry(16'h8206, 16'h1DA5, 0, `LC4_STALL_NONE);
        set_rf(3'd6, 16'hFFC7, 3'b100);
        add_entry(16'h8207, 16'h5E53, 0, `LC4_STALL_NONE);
        set_rf(3'd7, 16'h007D, 3'b001);
        add_entry(16'h8208, 16'h5FFC, 0, `LC4_STALL_NONE);
        set_rf(3'd7, 16'h007C, 3'b001);
        // a load then its user with one bubble between them
        add_entry(16'h8209, 16'h6442, 0, `LC4_STALL_NONE);
        set_rf(3'd2, ld_val, sign_bits(ld_val));
        set_mem(1'b0, 16'h0042, ld_val);
        add_entry(16'h820A, 16'h1681, 1, `LC4_STALL_LOAD);
        set_rf(3'd3, sum, sign_bits(sum));
        add_entry(16'h820B, 16'h7645, 0, `LC4_STALL_NONE);
        set_mem(1'b1, 16'h0045, sum);
        add_entry(16'h820C, 16'h6A45, 0, `LC4_STALL_NONE);
        set_rf(3'd5, sum, sign_bits(sum));
        set_mem(1'b0, 16'h0045, sum);
        add_entry(16'h820D, 16'h9000, 0, `LC4_STALL_NONE);
        set_rf(3'd0, 16'h0000, 3'b010);
        // BRn falls through, BRz goes to 8212
        add_entry(16'h820E, 16'h0805, 0, `LC4_STALL_NONE);
        add_entry(16'h820F, 16'h0402, 0, `LC4_STALL_NONE);
        add_entry(16'h8212, 16'h103F, 2, `LC4_STALL_BRANCH);
        set_rf(3'd0, 16'hFFFF, 3'b100);
        add_entry(16'h8213, 16'hC803, 0, `LC4_STALL_NONE);
        add_entry(16'h8217, 16'h1200, 2, `LC4_STALL_BRANCH);
        set_rf(3'd1, 16'hFFFE, 3'b100);
        add_entry(16'h8218, 16'h94FF, 0, `LC4_STALL_NONE);
        set_rf(3'd2, 16'h00FF, 3'b001);
        // shadow instructions that must be squashed
        imem[16'h8210] = 16'h9E01;
        imem[16'h8211] = 16'h9E02;
        imem[16'h8214] = 16'h9E03;
        imem[16'h8215] = 16'h9E04;
        imem[16'h8216] = 16'h9E05;
    endtask

    task automatic check_entry(input int i);
        check_word("retired pc", o_test_cur_pc, e_pc[i]);
        check_insn("retired insn", o_test_cur_insn, e_insn[i]);
        check_flag("regfile we", o_test_regfile_we, e_rf_we[i]);
        check_flag("nzp we", o_test_nzp_we, e_rf_we[i]);
        check_flag("dmem we", o_test_dmem_we, e_dm_we[i]);
        check_word("dmem addr", o_test_dmem_addr, e_dm_addr[i]);
        check_word("dmem data", o_test_dmem_data, e_dm_data[i]);
        if (e_rf_we[i]) begin
            check_sel("regfile wsel", o_test_regfile_wsel, e_wsel[i]);
            check_word("regfile data", o_test_regfile_data, e_data[i]);
            check_nzp("nzp bits", o_test_nzp_new_bits, e_nzp[i]);
        end
    endtask

    initial begin
        word_t w;
        int nb;
        i_rst           = 1'b1;
        i_cur_insn      = '0;
        i_cur_dmem_data = '0;
        err_count       = 0;
        check_count     = 0;
        n_entries       = 0;
        lfsr_state      = 32'd90526;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = '0;
            dmem[a] = word_t'(a) ^ 16'hA5C3;
        end
        for (int a = 16'h0040; a < 16'h0048; a++) begin
            lfsr_word(w);
            dmem[a] = w;
        end
        build_program();
        repeat (8) @(negedge gwe);
        // fetch address and memory write enable while reset is held
        check_word("fetch pc in reset", o_cur_pc, `LC4_RESET_PC);
        check_flag("dmem write enable in reset", o_dmem_we, 1'b0);
        i_rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            nb = 0;
            @(negedge gwe);
            while (o_test_stall != `LC4_STALL_NONE) begin
                // bubbles carry no enables
                check_stall("bubble stall code", o_test_stall, e_bcode[i]);
                check_flag("bubble regfile we", o_test_regfile_we, 1'b0);
                check_flag("bubble nzp we", o_test_nzp_we, 1'b0);
                check_flag("bubble dmem we", o_test_dmem_we, 1'b0);
                nb++;
                @(negedge gwe);
            end
            if (nb != e_bubbles[i]) begin
                err_count++;
                $display("ERR %0t: %0d bubbles before pc %h, expected %0d",
                         $time, nb, e_pc[i], e_bubbles[i]);
            end
            check_entry(i);
        end
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized to the program length
    initial begin
        @(negedge gwe);
        repeat (n_entries * 4 + 40) @(posedge gwe);
        $display("the pipeline stopped retiring the expected instructions in time");
        $display("checks: %0d, errors: %0d", check_count, err_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/lc4_isa_pkg.sv
hw/lc4_pipe_pkg.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_alu.sv
hw/lc4_hazard_unit.sv
hw/lc4_pipeline.sv
bench/tb_lc4_pipeline.sv

//--- hw/lc4_alu.sv
// **************************************************************************
// LC4 execute unit
// result, memory address or branch target of the instruction in X
// **************************************************************************
`timescale 1ns/10ps

module lc4_alu (
    input  lc4_isa_pkg::insn_t i_insn,
    input  lc4_isa_pkg::word_t i_pc,
    input  lc4_isa_pkg::word_t i_rs_data,
    input  lc4_isa_pkg::word_t i_rt_data,
    output lc4_isa_pkg::word_t o_result
);
    import lc4_isa_pkg::*;

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t imm11;
    word_t pc_inc;

    // sign-extended immediate fields
    assign imm5   = word_t'($signed(i_insn[4:0]));
    assign imm6   = word_t'($signed(i_insn[5:0]));
    assign imm9   = word_t'($signed(i_insn[8:0]));
    assign imm11  = word_t'($signed(i_insn[10:0]));
    assign pc_inc = i_pc + 16'd1;

    always_comb begin
        case (opcode_t'(i_insn[15:12]))
            OP_BR:    o_result = pc_inc + imm9;
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else if (i_insn[4]) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + i_rt_data;
                end
            end
            OP_LOGIC: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data & imm5;
                end else begin
                    case (i_insn[4:3])
                        2'b00:   o_result = i_rs_data & i_rt_data;
                        2'b01:   o_result = ~i_rs_data;
                        2'b10:   o_result = i_rs_data | i_rt_data;
                        default: o_result = i_rs_data ^ i_rt_data;
                    endcase
                end
            end
            // base plus offset
            OP_LDR,
            OP_STR:   o_result = i_rs_data + imm6;
            OP_CONST: o_result = imm9;
            OP_JMP:   o_result = pc_inc + imm11;
            default:  o_result = '0;
        endcase
    end

endmodule

//--- hw/lc4_config.svh
// **************************************************************************
// LC4 pipeline configuration
// reset fetch address, register count and writeback stall codes
// **************************************************************************
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// first fetch address after reset
`define LC4_RESET_PC      16'h8200

`define LC4_NUM_REGS      8

// stall codes carried with every retired slot
`define LC4_STALL_NONE    2'd0
`define LC4_STALL_BRANCH  2'd2
`define LC4_STALL_LOAD    2'd3

`endif

//--- hw/lc4_decoder.sv
// **************************************************************************
// LC4 decoder
// turns one instruction into register selects and control flags
// **************************************************************************
`timescale 1ns/10ps

module lc4_decoder (
    input  lc4_isa_pkg::insn_t    i_insn,
    output lc4_isa_pkg::reg_sel_t o_r1sel,
    output lc4_isa_pkg::reg_sel_t o_r2sel,
    output lc4_isa_pkg::reg_sel_t o_wsel,
    output logic                  o_r1re,
    output logic                  o_r2re,
    output logic                  o_regfile_we,
    output logic                  o_nzp_we,
    output logic                  o_is_load,
    output logic                  o_is_store,
    output logic                  o_is_branch,
    output logic                  o_is_jump
);
    import lc4_isa_pkg::*;

    opcode_t op;
    logic    alu_valid;

    assign op = opcode_t'(i_insn[15:12]);

    // arith keeps ADD, SUB and ADD immediate, MUL and DIV become NOPs
    assign alu_valid = (op == OP_LOGIC) || (op == OP_ARITH && (i_insn[5] || !i_insn[3]));

    always_comb begin
        o_r1sel      = i_insn[8:6];
        // STR carries its data register in the destination field
        o_r2sel      = (op == OP_STR) ? i_insn[11:9] : i_insn[2:0];
        o_wsel       = i_insn[11:9];
        o_r1re       = alu_valid || op == OP_LDR || op == OP_STR;
        // NOT and the immediate forms have no second source
        o_r2re       = op == OP_STR ||
                       (alu_valid && !i_insn[5] && !(op == OP_LOGIC && i_insn[4:3] == 2'b01));
        o_regfile_we = alu_valid || op == OP_LDR || op == OP_CONST;
        o_nzp_we     = o_regfile_we;
        o_is_load    = op == OP_LDR;
        o_is_store   = op == OP_STR;
        // nzp of 000 is a NOP and reads nothing
        o_is_branch  = op == OP_BR && |i_insn[11:9];
        o_is_jump    = op == OP_JMP && i_insn[11];
    end

endmodule

//--- hw/lc4_hazard_unit.sv
// **************************************************************************
// LC4 hazard unit
// load-to-use stall, MX/WX operand bypass and WM store-data bypass
// **************************************************************************
`timescale 1ns/10ps

module lc4_hazard_unit (
    input  lc4_isa_pkg::reg_sel_t i_d_r1sel,
    input  lc4_isa_pkg::reg_sel_t i_d_r2sel,
    input  logic                  i_d_r1re,
    input  logic                  i_d_r2re,
    input  logic                  i_d_is_branch,
    input  lc4_isa_pkg::reg_sel_t i_x_r1sel,
    input  lc4_isa_pkg::reg_sel_t i_x_r2sel,
    input  lc4_isa_pkg::reg_sel_t i_x_wsel,
    input  logic                  i_x_r1re,
    input  logic                  i_x_r2re,
    input  logic                  i_x_is_load,
    input  lc4_isa_pkg::word_t    i_x_rs_reg,
    input  lc4_isa_pkg::word_t    i_x_rt_reg,
    input  lc4_isa_pkg::reg_sel_t i_m_wsel,
    input  lc4_isa_pkg::reg_sel_t i_m_r2sel,
    input  logic                  i_m_regfile_we,
    input  logic                  i_m_is_store,
    input  lc4_isa_pkg::word_t    i_m_result,
    input  lc4_isa_pkg::word_t    i_m_rt_reg,
    input  lc4_isa_pkg::reg_sel_t i_w_wsel,
    input  logic                  i_w_regfile_we,
    input  lc4_isa_pkg::word_t    i_w_wdata,
    output logic                  o_stall,
    output lc4_isa_pkg::word_t    o_x_rs_data,
    output lc4_isa_pkg::word_t    o_x_rt_data,
    output lc4_isa_pkg::word_t    o_m_store_data
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    byp_sel_t rs_sel;
    byp_sel_t rt_sel;
    logic     d_needs_load;

    // the youngest writer wins, so M is checked before W
    function automatic byp_sel_t pick_src(input reg_sel_t sel, input logic re);
        if (re && i_m_regfile_we && i_m_wsel == sel) begin
            return BYP_M;
        end
        if (re && i_w_regfile_we && i_w_wsel == sel) begin
            return BYP_W;
        end
        return BYP_RF;
    endfunction

    function automatic word_t pick_data(input byp_sel_t src, input word_t reg_val);
        case (src)
            BYP_M:   return i_m_result;
            BYP_W:   return i_w_wdata;
            default: return reg_val;
        endcase
    endfunction

    // a BR reads nzp, which a load only sets at the end of M
    assign d_needs_load = (i_d_r1re && i_d_r1sel == i_x_wsel) ||
                          (i_d_r2re && i_d_r2sel == i_x_wsel) ||
                          i_d_is_branch;
    assign o_stall = i_x_is_load && d_needs_load;

    always_comb begin
        rs_sel      = pick_src(i_x_r1sel, i_x_r1re);
        rt_sel      = pick_src(i_x_r2sel, i_x_r2re);
        o_x_rs_data = pick_data(rs_sel, i_x_rs_reg);
        o_x_rt_data = pick_data(rt_sel, i_x_rt_reg);
        if (i_m_is_store && i_w_regfile_we && i_w_wsel == i_m_r2sel) begin
            o_m_store_data = i_w_wdata;
        end else begin
            o_m_store_data = i_m_rt_reg;
        end
    end

endmodule

//--- hw/lc4_isa_pkg.sv
// **************************************************************************
// LC4 ISA types
// words, instructions, register selects, condition bits and opcodes
// **************************************************************************
package lc4_isa_pkg;

    // data word, PC or address
    typedef logic [15:0] word_t;

    typedef logic [15:0] insn_t;

    typedef logic [2:0] reg_sel_t;

    // condition bits, negative in bit 2 and positive in bit 0
    typedef logic [2:0] nzp_t;

    typedef logic [3:0] opcode_t;

    // opcodes of the supported subset
    localparam opcode_t OP_BR    = 4'b0000;
    localparam opcode_t OP_ARITH = 4'b0001;
    localparam opcode_t OP_LOGIC = 4'b0101;
    localparam opcode_t OP_LDR   = 4'b0110;
    localparam opcode_t OP_STR   = 4'b0111;
    localparam opcode_t OP_CONST = 4'b1001;
    localparam opcode_t OP_JMP   = 4'b1100;

endpackage

//--- hw/lc4_pipe_pkg.sv
// **************************************************************************
// LC4 pipeline types
// stall codes and operand bypass sources
// **************************************************************************
package lc4_pipe_pkg;

    typedef logic [1:0] stall_t;

    // where an X-stage operand comes from
    typedef logic [1:0] byp_sel_t;

    localparam byp_sel_t BYP_RF = 2'd0;
    localparam byp_sel_t BYP_M  = 2'd1;
    localparam byp_sel_t BYP_W  = 2'd2;

endpackage

//--- hw/lc4_pipeline.sv
// **************************************************************************
// LC4 five-stage pipeline
// fetch, decode, execute, memory and writeback with a retirement trace
// **************************************************************************
`timescale 1ns/10ps
`include "lc4_config.svh"

module lc4_pipeline (
    input  logic                  gwe,
    input  logic                  i_rst,
    output lc4_isa_pkg::word_t    o_cur_pc,
    input  lc4_isa_pkg::insn_t    i_cur_insn,
    output lc4_isa_pkg::word_t    o_dmem_addr,
    output lc4_isa_pkg::word_t    o_dmem_towrite,
    output logic                  o_dmem_we,
    input  lc4_isa_pkg::word_t    i_cur_dmem_data,
    output lc4_pipe_pkg::stall_t  o_test_stall,
    output lc4_isa_pkg::word_t    o_test_cur_pc,
    output lc4_isa_pkg::insn_t    o_test_cur_insn,
    output logic                  o_test_regfile_we,
    output logic                  o_test_nzp_we,
    output logic                  o_test_dmem_we,
    output lc4_isa_pkg::reg_sel_t o_test_regfile_wsel,
    output lc4_isa_pkg::word_t    o_test_regfile_data,
    output lc4_isa_pkg::word_t    o_test_dmem_addr,
    output lc4_isa_pkg::word_t    o_test_dmem_data,
    output lc4_isa_pkg::nzp_t     o_test_nzp_new_bits
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    // fetch and decode
    word_t    f_pc, next_pc, d_pc;
    insn_t    d_insn;
    stall_t   d_stall;
    reg_sel_t d_r1sel, d_r2sel, d_wsel;
    logic     d_r1re, d_r2re, d_regfile_we, d_nzp_we;
    logic     d_is_load, d_is_store, d_is_branch, d_is_jump;
    word_t    rf_rs_data, rf_rt_data;
    logic     stall;

    // execute
    word_t    x_pc;
    insn_t    x_insn;
    stall_t   x_stall;
    reg_sel_t x_r1sel, x_r2sel, x_wsel;
    logic     x_r1re, x_r2re, x_regfile_we, x_nzp_we;
    logic     x_is_load, x_is_store, x_is_branch, x_is_jump;
    word_t    x_rs_reg, x_rt_reg, x_rs_data, x_rt_data, alu_result;
    logic     x_taken;
    nzp_t     nzp_reg;

    // memory and writeback
    word_t    m_pc, m_result, m_rt_reg, m_store_data;
    insn_t    m_insn;
    stall_t   m_stall;
    reg_sel_t m_wsel, m_r2sel;
    logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store;
    word_t    w_pc, w_result, w_load_data, w_store_data, w_wdata;
    insn_t    w_insn;
    stall_t   w_stall;
    reg_sel_t w_wsel;
    logic     w_regfile_we, w_nzp_we, w_is_load, w_is_store;

    function automatic nzp_t nzp_of(input word_t value);
        if (value == '0) begin
            return 3'b010;
        end
        return value[15] ? 3'b100 : 3'b001;
    endfunction

    // branch and jump resolve in X
    assign x_taken = (x_is_branch && |(x_insn[11:9] & nzp_reg)) || x_is_jump;
    assign next_pc = x_taken ? alu_result : (stall ? f_pc : f_pc + 16'd1);

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            f_pc <= `LC4_RESET_PC;
        end else begin
            f_pc <= next_pc;
        end
    end

    // D holds on a stall and is squashed by a taken branch
    always_ff @(posedge gwe) begin
        if (i_rst || x_taken) begin
            d_insn  <= '0;
            d_stall <= `LC4_STALL_BRANCH;
        end else if (!stall) begin
            d_pc    <= f_pc;
            d_insn  <= i_cur_insn;
            d_stall <= `LC4_STALL_NONE;
        end
    end

    lc4_decoder u_decoder (
        .i_insn       (d_insn),
        .o_r1sel      (d_r1sel),
        .o_r2sel      (d_r2sel),
        .o_wsel       (d_wsel),
        .o_r1re       (d_r1re),
        .o_r2re       (d_r2re),
        .o_regfile_we (d_regfile_we),
        .o_nzp_we     (d_nzp_we),
        .o_is_load    (d_is_load),
        .o_is_store   (d_is_store),
        .o_is_branch  (d_is_branch),
        .o_is_jump    (d_is_jump)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs      (d_r1sel),
        .i_rt      (d_r2sel),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data),
        .i_rd      (w_wsel),
        .i_wdata   (w_wdata),
        .i_rd_we   (w_regfile_we)
    );

    always_ff @(posedge gwe) begin
        x_pc     <= d_pc;
        x_r1sel  <= d_r1sel;
        x_r2sel  <= d_r2sel;
        x_wsel   <= d_wsel;
        x_rs_reg <= rf_rs_data;
        x_rt_reg <= rf_rt_data;
        if (i_rst || x_taken || stall) begin
            // flushed or load-use slot enters X as a bubble
            x_insn       <= '0;
            x_stall      <= (i_rst || x_taken) ? `LC4_STALL_BRANCH : `LC4_STALL_LOAD;
            x_r1re       <= 1'b0;
            x_r2re       <= 1'b0;
            x_regfile_we <= 1'b0;
            x_nzp_we     <= 1'b0;
            x_is_load    <= 1'b0;
            x_is_store   <= 1'b0;
            x_is_branch  <= 1'b0;
            x_is_jump    <= 1'b0;
        end else begin
            x_insn       <= d_insn;
            x_stall      <= d_stall;
            x_r1re       <= d_r1re;
            x_r2re       <= d_r2re;
            x_regfile_we <= d_regfile_we;
            x_nzp_we     <= d_nzp_we;
            x_is_load    <= d_is_load;
            x_is_store   <= d_is_store;
            x_is_branch  <= d_is_branch;
            x_is_jump    <= d_is_jump;
        end
    end

    lc4_hazard_unit u_hazard_unit (
        .i_d_r1sel      (d_r1sel),
        .i_d_r2sel      (d_r2sel),
        .i_d_r1re       (d_r1re),
        .i_d_r2re       (d_r2re),
        .i_d_is_branch  (d_is_branch),
        .i_x_r1sel      (x_r1sel),
        .i_x_r2sel      (x_r2sel),
        .i_x_wsel       (x_wsel),
        .i_x_r1re       (x_r1re),
        .i_x_r2re       (x_r2re),
        .i_x_is_load    (x_is_load),
        .i_x_rs_reg     (x_rs_reg),
        .i_x_rt_reg     (x_rt_reg),
        .i_m_wsel       (m_wsel),
        .i_m_r2sel      (m_r2sel),
        .i_m_regfile_we (m_regfile_we),
        .i_m_is_store   (m_is_store),
        .i_m_result     (m_result),
        .i_m_rt_reg     (m_rt_reg),
        .i_w_wsel       (w_wsel),
        .i_w_regfile_we (w_regfile_we),
        .i_w_wdata      (w_wdata),
        .o_stall        (stall),
        .o_x_rs_data    (x_rs_data),
        .o_x_rt_data    (x_rt_data),
        .o_m_store_data (m_store_data)
    );

    lc4_alu u_alu (
        .i_insn    (x_insn),
        .i_pc      (x_pc),
        .i_rs_data (x_rs_data),
        .i_rt_data (x_rt_data),
        .o_result  (alu_result)
    );

    // the younger op in X wins over a load finishing in M
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_reg <= '0;
        end else if (x_nzp_we && !x_is_load) begin
            nzp_reg <= nzp_of(alu_result);
        end else if (m_nzp_we && m_is_load) begin
            nzp_reg <= nzp_of(i_cur_dmem_data);
        end
    end

    always_ff @(posedge gwe) begin
        m_pc     <= x_pc;
        m_insn   <= x_insn;
        m_wsel   <= x_wsel;
        m_r2sel  <= x_r2sel;
        m_result <= alu_result;
        m_rt_reg <= x_rt_data;
        if (i_rst) begin
            m_stall      <= `LC4_STALL_BRANCH;
            m_regfile_we <= 1'b0;
            m_nzp_we     <= 1'b0;
            m_is_load    <= 1'b0;
            m_is_store   <= 1'b0;
        end else begin
            m_stall      <= x_stall;
            m_regfile_we <= x_regfile_we;
            m_nzp_we     <= x_nzp_we;
            m_is_load    <= x_is_load;
            m_is_store   <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        w_pc         <= m_pc;
        w_insn       <= m_insn;
        w_wsel       <= m_wsel;
        w_result     <= m_result;
        w_load_data  <= i_cur_dmem_data;
        w_store_data <= m_store_data;
        if (i_rst) begin
            w_stall      <= `LC4_STALL_BRANCH;
            w_regfile_we <= 1'b0;
            w_nzp_we     <= 1'b0;
            w_is_load    <= 1'b0;
            w_is_store   <= 1'b0;
        end else begin
            w_stall      <= m_stall;
            w_regfile_we <= m_regfile_we;
            w_nzp_we     <= m_nzp_we;
            w_is_load    <= m_is_load;
            w_is_store   <= m_is_store;
        end
    end

    assign w_wdata = w_is_load ? w_load_data : w_result;

    assign o_cur_pc       = f_pc;
    assign o_dmem_addr    = m_result;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = m_store_data;

    // retirement trace
    assign o_test_stall        = w_stall;
    assign o_test_cur_pc       = w_pc;
    assign o_test_cur_insn     = w_insn;
    assign o_test_regfile_we   = w_regfile_we;
    assign o_test_regfile_wsel = w_wsel;
    assign o_test_regfile_data = w_wdata;
    assign o_test_nzp_we       = w_nzp_we;
    assign o_test_nzp_new_bits = nzp_of(w_wdata);
    assign o_test_dmem_we      = w_is_store;
    assign o_test_dmem_addr    = (w_is_load || w_is_store) ? w_result : '0;
    assign o_test_dmem_data    = w_is_load ? w_load_data : (w_is_store ? w_store_data : '0);

endmodule

//--- hw/lc4_regfile.sv
// **************************************************************************
// LC4 register file
// eight registers, two read ports with write-through, one write port
// **************************************************************************
`timescale 1ns/10ps
`include "lc4_config.svh"

module lc4_regfile (
    input  logic                  gwe,
    input  logic                  i_rst,
    input  lc4_isa_pkg::reg_sel_t i_rs,
    input  lc4_isa_pkg::reg_sel_t i_rt,
    output lc4_isa_pkg::word_t    o_rs_data,
    output lc4_isa_pkg::word_t    o_rt_data,
    input  lc4_isa_pkg::reg_sel_t i_rd,
    input  lc4_isa_pkg::word_t    i_wdata,
    input  logic                  i_rd_we
);
    import lc4_isa_pkg::*;

    word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // D reads the value that W is retiring this cycle
    assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_lc4_pipeline -o tb_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log

grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log && exit 0 || exit 1
